/* Bender.yml */
package:
  name: cpu_board_bus

sources:
  - soc_pkg.sv
  - ps2_receiver.sv
  - key_irq_unit.sv
  - board_memory.sv
  - bus_controller.sv
  - uart_credit_tx.sv
  - cpu_board_bus.sv
  - target: simulation
    files:
      - tb_cpu_board_bus.sv

/* board_memory.sv */
module board_memory (
    input  logic              clk,
    input  soc_pkg::addr_t    fetch_addr,
    output soc_pkg::word_t    instr,
    input  soc_pkg::mem_idx_t b_idx,
    input  logic              b_we,
    input  soc_pkg::word_t    b_wdata,
    output soc_pkg::word_t    b_rdata
);
    import soc_pkg::*;

    // Unified word array, ROM words first then RAM
    word_t    mem [MEM_WORDS];

    mem_idx_t fetch_idx;
    word_t    fetch_q;

    // Program image sits at word 0
    initial begin
        $readmemh("rom.hex", mem);
    end

    // Byte address to word index
    assign fetch_idx = fetch_addr[11:2];

    // Port A, instruction fetch
    always_ff @(posedge clk) begin
        fetch_q <= mem[fetch_idx];
    end

    // Stored words are little endian, the core wants them reversed
    assign instr = {fetch_q[7:0], fetch_q[15:8], fetch_q[23:16], fetch_q[31:24]};

    // Port B, data bus
    // Read returns the old word on a same-cycle write
    always @(posedge clk) begin
        if (b_we) begin
            mem[b_idx] <= b_wdata;
        end
        b_rdata <= mem[b_idx];
    end

endmodule

/* bus_controller.sv */
module bus_controller (
    input  logic              clk,
    input  logic              rst_n,
    input  soc_pkg::bus_req_t req,
    output soc_pkg::bus_rsp_t rsp,
    output soc_pkg::mem_idx_t b_idx,
    output logic              b_we,
    output soc_pkg::word_t    b_wdata,
    input  soc_pkg::word_t    b_rdata,
    output logic              key_rd,
    input  soc_pkg::word_t    key_word,
    output logic              push,
    output soc_pkg::byte_t    push_data,
    input  logic              full
);
    import soc_pkg::*;

    // Region decode
    logic  rom_sel;
    logic  ram_sel;
    logic  key_sel;
    logic  uart_sel;

    logic  uart_stall;
    logic  rd_acc;
    logic  wr_acc;

    // Read source of the previous accepted read
    logic  rd_valid_q;
    logic  src_mem_q;
    logic  src_key_q;
    word_t key_q;

    assign rom_sel  = (req.addr >= ROM_BASE) && (req.addr < ROM_BASE + ROM_SIZE);
    assign ram_sel  = (req.addr >= RAM_BASE) && (req.addr < RAM_BASE + RAM_SIZE);
    assign key_sel  = (req.addr == KEY_ADDR);
    assign uart_sel = (req.addr == UART_ADDR);

    // Hold the master off while the UART FIFO is full
    assign uart_stall = req.wr_en && uart_sel && full;

    assign rsp.ack = (req.rd_en || req.wr_en) && !uart_stall;
    assign rd_acc  = req.rd_en && rsp.ack;
    assign wr_acc  = req.wr_en && rsp.ack;

    // Memory port B, ROM and RAM share one word index space
    assign b_idx   = req.addr[11:2];
    // ROM writes are dropped here
    assign b_we    = wr_acc && ram_sel;
    assign b_wdata = req.wdata;

    // Side effects of accepted accesses
    assign key_rd    = rd_acc && key_sel;
    assign push      = wr_acc && uart_sel;
    assign push_data = req.wdata[7:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_q <= 1'b0;
            src_mem_q  <= 1'b0;
            src_key_q  <= 1'b0;
        end else begin
            rd_valid_q <= rd_acc;
            src_mem_q  <= rd_acc && (rom_sel || ram_sel);
            src_key_q  <= rd_acc && key_sel;
        end
    end

    // Key word captured before the read clears its valid bit
    always_ff @(posedge clk) begin
        if (rd_acc && key_sel) begin
            key_q <= key_word;
        end
    end

    // Unmapped reads come back as zero
    always_comb begin
        if (src_mem_q) begin
            rsp.rdata = b_rdata;
        end else if (src_key_q) begin
            rsp.rdata = key_q;
        end else begin
            rsp.rdata = '0;
        end
    end

    assign rsp.rd_valid = rd_valid_q;

endmodule

/* cpu_board_bus.f */
soc_pkg.sv
ps2_receiver.sv
key_irq_unit.sv
board_memory.sv
bus_controller.sv
uart_credit_tx.sv
cpu_board_bus.sv
tb_cpu_board_bus.sv

/* cpu_board_bus.sv */
module cpu_board_bus (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    input  logic              PS2_CLK,
    input  logic              PS2_DAT,
    input  soc_pkg::addr_t    fetch_addr,
    output soc_pkg::word_t    instr,
    input  soc_pkg::bus_req_t req,
    output soc_pkg::bus_rsp_t rsp,
    output logic              irq,
    input  logic              irq_ack,
    output logic              tx_valid,
    output soc_pkg::byte_t    tx_data,
    input  logic              credit_return
);
    import soc_pkg::*;

    // Keyboard path
    byte_t    code;
    logic     code_valid;
    word_t    key_word;
    logic     key_rd;

    // Memory port B
    mem_idx_t b_idx;
    logic     b_we;
    word_t    b_wdata;
    word_t    b_rdata;

    // UART push side
    logic     push;
    byte_t    push_data;
    logic     full;

    // Input side
    ps2_receiver u_ps2 (
        .clk        (CLOCK_50),
        .rst_n      (KEY0),
        .ps2_clk    (PS2_CLK),
        .ps2_dat    (PS2_DAT),
        .code       (code),
        .code_valid (code_valid)
    );

    key_irq_unit u_key (
        .clk        (CLOCK_50),
        .rst_n      (KEY0),
        .code       (code),
        .code_valid (code_valid),
        .key_rd     (key_rd),
        .irq_ack    (irq_ack),
        .key_word   (key_word),
        .irq        (irq)
    );

    // Bus and memory
    bus_controller u_bus (
        .clk       (CLOCK_50),
        .rst_n     (KEY0),
        .req       (req),
        .rsp       (rsp),
        .b_idx     (b_idx),
        .b_we      (b_we),
        .b_wdata   (b_wdata),
        .b_rdata   (b_rdata),
        .key_rd    (key_rd),
        .key_word  (key_word),
        .push      (push),
        .push_data (push_data),
        .full      (full)
    );

    board_memory u_mem (
        .clk        (CLOCK_50),
        .fetch_addr (fetch_addr),
        .instr      (instr),
        .b_idx      (b_idx),
        .b_we       (b_we),
        .b_wdata    (b_wdata),
        .b_rdata    (b_rdata)
    );

    // Output side
    uart_credit_tx u_uart (
        .clk           (CLOCK_50),
        .rst_n         (KEY0),
        .push          (push),
        .push_data     (push_data),
        .full          (full),
        .tx_valid      (tx_valid),
        .tx_data       (tx_data),
        .credit_return (credit_return)
    );

endmodule

/* key_irq_unit.sv */
module key_irq_unit (
    input  logic           clk,
    input  logic           rst_n,
    input  soc_pkg::byte_t code,
    input  logic           code_valid,
    input  logic           key_rd,
    input  logic           irq_ack,
    output soc_pkg::word_t key_word,
    output logic           irq
);
    import soc_pkg::*;

    logic  break_pend;
    logic  key_valid;
    byte_t key_code;
    logic  is_make;

    // Make code: not the prefix and not the byte after it
    assign is_make = code_valid && !break_pend && (code != BREAK_CODE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            break_pend <= 1'b0;
            key_valid  <= 1'b0;
            key_code   <= '0;
            irq        <= 1'b0;
        end else begin
            // Any received byte updates the prefix flag
            // Release byte clears it again
            if (code_valid) begin
                break_pend <= (code == BREAK_CODE);
            end

            // Latest make code wins over a read in the same cycle
            if (is_make) begin
                key_code  <= code;
                key_valid <= 1'b1;
            end else if (key_rd) begin
                key_valid <= 1'b0;
            end

            // Interrupt request, set beats acknowledge
            if (is_make) begin
                irq <= 1'b1;
            end else if (irq_ack) begin
                irq <= 1'b0;
            end
        end
    end

    // Bit 8 valid, low byte scan code
    assign key_word = {23'd0, key_valid, key_code};

endmodule

/* ps2_receiver.sv */
module ps2_receiver (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           ps2_clk,
    input  logic           ps2_dat,
    output soc_pkg::byte_t code,
    output logic           code_valid
);
    import soc_pkg::*;

    // Two flop synchronizers, both lines idle high
    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    logic       clk_prev;
    logic       fall;
    logic       dat_bit;

    ps2_state_t state;
    logic [2:0] bit_cnt;
    byte_t      shift_q;
    logic       parity_q;
    logic       frame_ok;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    // Falling PS2_CLK edge, one system clock wide
    assign fall    = clk_prev && !clk_sync[1];
    assign dat_bit = dat_sync[1];

    // Odd parity over data plus parity bit, stop bit must be one
    assign frame_ok = dat_bit && (^{shift_q, parity_q});

    // Frame sequencing
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= PS2_IDLE;
            bit_cnt    <= '0;
            code_valid <= 1'b0;
        end else begin
            code_valid <= 1'b0;
            if (fall) begin
                case (state)
                    PS2_IDLE: begin
                        // Start bit is a zero
                        if (!dat_bit) begin
                            state   <= PS2_DATA;
                            bit_cnt <= '0;
                        end
                    end
                    PS2_DATA: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= PS2_PARITY;
                        end
                    end
                    PS2_PARITY: begin
                        state <= PS2_STOP;
                    end
                    PS2_STOP: begin
                        // Bad frames just fall back to idle
                        code_valid <= frame_ok;
                        state      <= PS2_IDLE;
                    end
                    default: begin
                        state <= PS2_IDLE;
                    end
                endcase
            end
        end
    end

    // Data path, LSB arrives first
    always_ff @(posedge clk) begin
        if (fall) begin
            if (state == PS2_DATA) begin
                shift_q <= {dat_bit, shift_q[7:1]};
            end
            if (state == PS2_PARITY) begin
                parity_q <= dat_bit;
            end
            if (state == PS2_STOP && frame_ok) begin
                code <= shift_q;
            end
        end
    end

endmodule

/* rom.hex */
// One 32-bit instruction word per line, loaded from word 0
00500093
00a00113
002081b3
40208233
0030a023
0000a283
fe5ff06f
00000013

/* soc_pkg.sv */
package soc_pkg;

    // Widths with a meaning of their own
    // Byte address on the data bus and fetch port
    typedef logic [15:0] addr_t;
    // Data and instruction word
    typedef logic [31:0] word_t;
    // Scan codes and UART bytes
    typedef logic [7:0]  byte_t;
    // Word index into the unified memory
    typedef logic [9:0]  mem_idx_t;

    // Address map
    localparam addr_t ROM_BASE  = 16'h0000;
    localparam addr_t ROM_SIZE  = 16'h0400;
    localparam addr_t RAM_BASE  = 16'h0400;
    localparam addr_t RAM_SIZE  = 16'h0800;
    // 256 ROM words followed by 512 RAM words
    localparam int    MEM_WORDS = 768;
    localparam addr_t KEY_ADDR  = 16'h1000;
    localparam addr_t UART_ADDR = 16'h1004;

    // UART transmit sizing
    // Matches the receiver's buffer depth
    localparam int UART_CREDITS    = 4;
    localparam int UART_FIFO_DEPTH = 4;

    // PS/2 set 2 release prefix
    localparam byte_t BREAK_CODE = 8'hF0;

    // Counter and pointer widths for the UART path
    typedef logic [$clog2(UART_CREDITS + 1)-1:0]    credit_t;
    typedef logic [$clog2(UART_FIFO_DEPTH)-1:0]     fifo_ptr_t;
    typedef logic [$clog2(UART_FIFO_DEPTH + 1)-1:0] fifo_cnt_t;

    // Data bus request from the master
    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  rd_en;
        logic  wr_en;
    } bus_req_t;

    // Data bus response back to the master
    typedef struct packed {
        word_t rdata;
        logic  rd_valid;
        logic  ack;
    } bus_rsp_t;

    // PS/2 frame receiver states
    typedef enum logic [1:0] {
        PS2_IDLE,
        PS2_DATA,
        PS2_PARITY,
        PS2_STOP
    } ps2_state_t;

endpackage

/* tb_cpu_board_bus.sv */
module tb_cpu_board_bus;
    import soc_pkg::*;

    localparam int CLK_PERIOD = 4;
    // PS/2 clock is 20 system clocks per bit
    localparam int PS2_HALF = 10;
    localparam int PS2_FRAME_CYCLES = 11 * 2 * PS2_HALF + PS2_HALF;
    // Five frames, bus traffic, fetches and thirteen UART bytes
    localparam int TEST_CYCLES = 5 * PS2_FRAME_CYCLES + 40 * 4 + 8 * 4 + 13 * 12 + 60;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + 1000;

    logic     CLOCK_50;
    logic     KEY0;
    logic     PS2_CLK;
    logic     PS2_DAT;
    addr_t    fetch_addr;
    word_t    instr;
    bus_req_t req;
    bus_rsp_t rsp;
    logic     irq;
    logic     irq_ack;
    logic     tx_valid;
    byte_t    tx_data;
    logic     credit_return;

    int    value_errors = 0;
    int    timing_errors = 0;
    int    seed = 10;
    // UART sink state
    int    rx_count = 0;
    int    owed = 0;
    int    credits_model = UART_CREDITS;
    bit    hold_credits = 1'b0;
    byte_t exp_q [$];
    byte_t exp_byte;
    // Reference copies of ROM and RAM
    word_t rom_ref [256];
    word_t ram_model [addr_t];

    cpu_board_bus dut0 (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .PS2_CLK       (PS2_CLK),
        .PS2_DAT       (PS2_DAT),
        .fetch_addr    (fetch_addr),
        .instr         (instr),
        .req           (req),
        .rsp           (rsp),
        .irq           (irq),
        .irq_ack       (irq_ack),
        .tx_valid      (tx_valid),
        .tx_data       (tx_data),
        .credit_return (credit_return)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #(CLK_PERIOD / 2) CLOCK_50 = ~CLOCK_50;
    end

    // Outputs quiet while reset is held
    reset_quiet: assert property (@(posedge CLOCK_50)
        !KEY0 |-> (!irq && !rsp.ack && !rsp.rd_valid && !tx_valid))
        else begin
            timing_errors++;
            $display("Outputs were not quiet during reset");
        end
    // Reads never stall
    read_ack: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        req.rd_en |-> rsp.ack)
        else begin
            timing_errors++;
            $display("A read request was not acknowledged in its cycle");
        end
    // Only UART writes may be held off
    write_ack: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (req.wr_en && req.addr != UART_ADDR) |-> rsp.ack)
        else begin
            timing_errors++;
            $display("A non-UART write was stalled");
        end
    // rd_valid exactly one cycle after acceptance
    read_valid: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        (req.rd_en && rsp.ack) |=> rsp.rd_valid)
        else begin
            timing_errors++;
            $display("rd_valid did not follow an accepted read");
        end
    read_quiet: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
        !(req.rd_en && rsp.ack) |=> !rsp.rd_valid)
        else begin
            timing_errors++;
            $display("rd_valid rose without an accepted read");
        end

    task automatic next_cycle;
        @(posedge CLOCK_50);
        #1;
    endtask

    task automatic check_value(input string name, input word_t got, input word_t expected);
        assert (got === expected) else begin
            value_errors++;
            $display("Error %s: got 0x%h, expected 0x%h", name, got, expected);
        end
    endtask

    function automatic word_t swap_bytes(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    // Hold the request until the cycle that accepts it
    task automatic wait_accept;
        @(negedge CLOCK_50);
        while (!rsp.ack) begin
            @(negedge CLOCK_50);
        end
        next_cycle;
    endtask

    task automatic bus_write(input addr_t addr, input word_t data);
        req.addr  = addr;
        req.wdata = data;
        req.rd_en = 1'b0;
        req.wr_en = 1'b1;
        wait_accept;
        req.wr_en = 1'b0;
    endtask

    task automatic bus_read(input addr_t addr, output word_t data);
        req.addr  = addr;
        req.rd_en = 1'b1;
        req.wr_en = 1'b0;
        wait_accept;
        req.rd_en = 1'b0;
        // Data is due one cycle after the accepting edge
        @(negedge CLOCK_50);
        assert (rsp.rd_valid) else begin
            timing_errors++;
            $display("No rd_valid one cycle after an accepted read");
        end
        data = rsp.rdata;
        next_cycle;
    endtask

    task automatic send_ps2_frame(input byte_t data, input bit bad_parity);
        logic [10:0] frame;
        // Stop, odd parity, data LSB first, start
        frame = {1'b1, ~(^data) ^ bad_parity, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            PS2_DAT = frame[i];
            repeat (PS2_HALF) next_cycle;
            PS2_CLK = 1'b0;
            repeat (PS2_HALF) next_cycle;
            PS2_CLK = 1'b1;
        end
        PS2_DAT = 1'b1;
        repeat (PS2_HALF) next_cycle;
    endtask

    // UART sink with scoreboard and credit bookkeeping
    always @(negedge CLOCK_50) begin
        if (KEY0 && tx_valid) begin
            assert (credits_model > 0) else begin
                timing_errors++;
                $display("tx_valid was high with no credits left");
            end
            credits_model--;
            owed++;
            rx_count++;
            if (exp_q.size() == 0) begin
                timing_errors++;
                $display("A UART byte left that was never written");
            end else begin
                exp_byte = exp_q.pop_front();
                check_value("tx_data", word_t'(tx_data), word_t'(exp_byte));
            end
        end
    end

    // Credits go back after a random delay unless withheld
    initial begin : credit_returner
        int delay;
        wait (KEY0 === 1'b1);
        forever begin
            next_cycle;
            if (owed > 0 && !hold_credits) begin
                delay = $random(seed) & 7;
                repeat (delay) next_cycle;
                credit_return = 1'b1;
                next_cycle;
                credit_return = 1'b0;
                owed--;
                credits_model++;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

    initial begin : main
        word_t rd;
        addr_t a;
        KEY0          = 1'b0;
        PS2_CLK       = 1'b1;
        PS2_DAT       = 1'b1;
        fetch_addr    = '0;
        req           = '0;
        irq_ack       = 1'b0;
        credit_return = 1'b0;
        $readmemh("rom.hex", rom_ref);

        // Reset and quiet outputs
        repeat (4) @(posedge CLOCK_50);
        #1;
        check_value("irq", word_t'(irq), 32'h0);
        check_value("tx_valid", word_t'(tx_valid), 32'h0);
        KEY0 = 1'b1;
        next_cycle;
        check_value("rsp.ack", word_t'(rsp.ack), 32'h0);
        check_value("rsp.rd_valid", word_t'(rsp.rd_valid), 32'h0);

        // Fetch gives the byte-reversed word and a bus read the plain one
        for (int i = 0; i < 8; i++) begin
            fetch_addr = addr_t'(i * 4);
            @(negedge CLOCK_50);
            // Previous word still on instr until the next edge
            if (i > 0) begin
                check_value("instr", instr, swap_bytes(rom_ref[i - 1]));
            end
            next_cycle;
            @(negedge CLOCK_50);
            check_value("instr", instr, swap_bytes(rom_ref[i]));
            next_cycle;
            bus_read(addr_t'(i * 4), rd);
            check_value("rsp.rdata", rd, rom_ref[i]);
        end

        // RAM write and read back
        for (int i = 0; i < 4; i++) begin
            a = RAM_BASE + addr_t'(i * 16'h027C);
            ram_model[a] = $random(seed);
            bus_write(a, ram_model[a]);
        end
        for (int i = 0; i < 4; i++) begin
            a = RAM_BASE + addr_t'(i * 16'h027C);
            bus_read(a, rd);
            check_value("rsp.rdata", rd, ram_model[a]);
        end
        // ROM write is dropped and unmapped space reads zero
        bus_write(16'h0008, 32'hDEADBEEF);
        bus_read(16'h0008, rd);
        check_value("rsp.rdata", rd, rom_ref[2]);
        bus_write(16'h2000, 32'h12345678);
        bus_read(16'h0C00, rd);
        check_value("rsp.rdata", rd, 32'h0);
        bus_read(16'h2000, rd);
        check_value("rsp.rdata", rd, 32'h0);

        // Make code sets irq and valid
        send_ps2_frame(8'h1C, 1'b0);
        check_value("irq", word_t'(irq), 32'h1);
        bus_read(KEY_ADDR, rd);
        check_value("key_word", rd, {23'd0, 1'b1, 8'h1C});
        bus_read(KEY_ADDR, rd);
        check_value("key_word", rd, {23'd0, 1'b0, 8'h1C});
        irq_ack = 1'b1;
        next_cycle;
        irq_ack = 1'b0;
        @(negedge CLOCK_50);
        check_value("irq", word_t'(irq), 32'h0);
        next_cycle;
        // Release sequence and a corrupt frame leave the key alone
        send_ps2_frame(BREAK_CODE, 1'b0);
        send_ps2_frame(8'h1C, 1'b0);
        send_ps2_frame(8'h2B, 1'b1);
        check_value("irq", word_t'(irq), 32'h0);
        bus_read(KEY_ADDR, rd);
        check_value("key_word", rd, {23'd0, 1'b0, 8'h1C});
        // Receiver still takes a good frame afterwards
        send_ps2_frame(8'h2B, 1'b0);
        check_value("irq", word_t'(irq), 32'h1);
        bus_read(KEY_ADDR, rd);
        check_value("key_word", rd, {23'd0, 1'b1, 8'h2B});
        irq_ack = 1'b1;
        next_cycle;
        irq_ack = 1'b0;

        // UART bytes in order with credits flowing
        for (int k = 0; k < 4; k++) begin
            exp_q.push_back(byte_t'(8'h30 + k));
            bus_write(UART_ADDR, word_t'(32'h30 + k));
        end
        while (rx_count < 4 || owed > 0) next_cycle;

        // With credits withheld the FIFO fills and the ninth write stalls
        hold_credits = 1'b1;
        fork
            for (int k = 0; k < 9; k++) begin
                exp_q.push_back(byte_t'(8'h60 + k));
                bus_write(UART_ADDR, word_t'(32'h60 + k));
            end
            begin
                repeat (60) next_cycle;
                @(negedge CLOCK_50);
                check_value("tx byte count", rx_count, 4 + UART_CREDITS);
                assert (req.wr_en && !rsp.ack) else begin
                    timing_errors++;
                    $display("UART write was not stalled with a full FIFO");
                end
                next_cycle;
                hold_credits = 1'b0;
            end
        join
        while (rx_count < 13 || owed > 0) next_cycle;
        check_value("pending bytes", exp_q.size(), 32'h0);

        repeat (4) next_cycle;
        $display("Value errors: %0d, timing errors: %0d", value_errors, timing_errors);
        if (value_errors == 0 && timing_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* uart_credit_tx.sv */
module uart_credit_tx (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           push,
    input  soc_pkg::byte_t push_data,
    output logic           full,
    output logic           tx_valid,
    output soc_pkg::byte_t tx_data,
    input  logic           credit_return
);
    import soc_pkg::*;

    byte_t     fifo [UART_FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count;
    credit_t   credits;
    logic      send;

    assign full = (count == fifo_cnt_t'(UART_FIFO_DEPTH));

    // One byte per cycle while data and credit are both there
    assign send = (count != '0) && (credits != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credits  <= credit_t'(UART_CREDITS);
            tx_valid <= 1'b0;
        end else begin
            tx_valid <= send;
            if (push) begin
                wr_ptr <= (wr_ptr == fifo_ptr_t'(UART_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= (rd_ptr == fifo_ptr_t'(UART_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Occupancy, push and send may coincide
            case ({push, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Credits, a send and a return in one cycle cancel out
            case ({send, credit_return})
                2'b10: credits <= credits - 1'b1;
                2'b01: begin
                    // Surplus returns are ignored
                    if (credits != credit_t'(UART_CREDITS)) begin
                        credits <= credits + 1'b1;
                    end
                end
                default: credits <= credits;
            endcase
        end
    end

    // Byte storage and output register
    always_ff @(posedge clk) begin
        if (push) begin
            fifo[wr_ptr] <= push_data;
        end
        if (send) begin
            tx_data <= fifo[rd_ptr];
        end
    end

endmodule
